/* rtl/cmd_decoder.sv */
`timescale 1ns/10ps
`include "timetag_consts.svh"

module cmd_decoder import timetag_pkg::*; (
	input  logic     fx2_clk,
	input  logic     rst_n,
	input  byte_t    cmd,
	input  logic     cmd_wr,
	output tt_ctrl_t ctrl,
	output logic     flush,
	output logic     clr_ts
);

	logic [3:0] op;
	chan_mask_t arg;

	assign op  = cmd[7:4];
	assign arg = cmd[3:0];

	always_ff @(posedge fx2_clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl   <= '0;
			flush  <= 1'b0;
			clr_ts <= 1'b0;
		end else begin
			flush  <= 1'b0;
			clr_ts <= 1'b0;
			if (cmd_wr) begin
				unique case (op)
					`OP_START: begin
						ctrl.capture_on <= 1'b1;
						clr_ts          <= 1'b1;   // timestamps restart at zero
					end
					`OP_STOP: begin
						ctrl.capture_on <= 1'b0;
						flush           <= ctrl.capture_on;
					end
					`OP_DET_MASK:  ctrl.det_mask   <= arg;
					`OP_PULSE_ON:  ctrl.pulse_mask <= ctrl.pulse_mask | arg;
					`OP_PULSE_OFF: ctrl.pulse_mask <= ctrl.pulse_mask & ~arg;
					default: ;   // unknown opcode
				endcase
			end
		end
	end

endmodule

/* rtl/fx2_bidir.sv */
`timescale 1ns/10ps
`include "timetag_consts.svh"

module fx2_bidir import timetag_pkg::*; (
	input  logic       fx2_clk,
	input  logic       rst_n,
	input  logic [2:0] fx2_flags,
	output logic       fx2_slrd,
	output logic       fx2_slwr,
	output logic       fx2_sloe,
	output logic       fx2_pktend,
	output logic [1:0] fx2_fifoadr,
	inout  wire byte_t fx2_fd,
	input  byte_t      sample,
	input  logic       sample_rdy,
	output logic       sample_ack,
	output byte_t      cmd,
	output logic       cmd_wr,
	input  logic       flush
);

	fx2_state_e state;
	logic       pend_flush;   // packet end owed to the host
	logic       out_ne;
	logic       in_nf;

	assign out_ne = fx2_flags[0];
	assign in_nf  = fx2_flags[1];

	// ####################################################################
	// arbitration: command read, then sample write, then packet end
	// ####################################################################
	always_ff @(posedge fx2_clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= idle;
			fx2_fifoadr <= `EP_OUT;
			cmd_wr      <= 1'b0;
			pend_flush  <= 1'b0;
		end else begin
			cmd_wr <= 1'b0;
			unique case (state)
				idle: begin
					if (out_ne) begin
						fx2_fifoadr <= `EP_OUT;
						state       <= rd_oe;
					end else if (sample_rdy && in_nf) begin
						fx2_fifoadr <= `EP_IN;
						state       <= wr_strobe;
					end else if (pend_flush && in_nf) begin
						fx2_fifoadr <= `EP_IN;
						state       <= pktend;
					end
				end
				rd_oe:     state <= rd_strobe;   // let the FX2 drive the bus
				rd_strobe: begin
					cmd_wr <= 1'b1;
					state  <= idle;
				end
				wr_strobe: state <= idle;
				pktend: begin
					pend_flush <= 1'b0;
					state      <= idle;
				end
				default:   state <= idle;
			endcase
			if (flush)
				pend_flush <= 1'b1;
		end
	end

	// command byte latched on the read strobe
	always_ff @(posedge fx2_clk) begin
		if (state == rd_strobe)
			cmd <= fx2_fd;
	end

	assign fx2_sloe   = !(state == rd_oe || state == rd_strobe);
	assign fx2_slrd   = (state != rd_strobe);
	assign fx2_slwr   = (state != wr_strobe);
	assign fx2_pktend = (state != pktend);
	assign sample_ack = (state == wr_strobe);

	assign fx2_fd = (state == wr_strobe) ? sample : 'z;   // bus is ours only while writing

endmodule

/* rtl/fx2_timetag.sv */
`timescale 1ns/10ps
`include "timetag_consts.svh"

module fx2_timetag import timetag_pkg::*; (
	input  logic       fx2_clk,
	input  logic       rst_n,
	input  logic [2:0] fx2_flags,
	output logic       fx2_slwr,
	output logic       fx2_slrd,
	output logic       fx2_sloe,
	output logic       fx2_pktend,
	output logic [1:0] fx2_fifoadr,
	inout  wire byte_t fx2_fd,
	input  chan_mask_t detectors,
	output chan_mask_t laser_en,
	output logic [1:0] led
);

	byte_t    cmd;
	logic     cmd_wr;
	byte_t    sample;
	logic     sample_rdy;
	logic     sample_ack;
	logic     flush;
	tt_ctrl_t ctrl;

	fx2_bidir fx2_if (.fx2_clk, .rst_n, .fx2_flags, .fx2_slrd, .fx2_slwr, .fx2_sloe,
		.fx2_pktend, .fx2_fifoadr, .fx2_fd, .sample, .sample_rdy, .sample_ack,
		.cmd, .cmd_wr, .flush);

	timetag tt_core (.fx2_clk, .rst_n, .cmd, .cmd_wr, .detectors, .sample_ack,
		.laser_en, .sample, .sample_rdy, .ctrl, .flush);

	assign led[0] = ctrl.capture_on;
	assign led[1] = |ctrl.pulse_mask;   // any channel pulsing

endmodule

/* rtl/pulse_seq.sv */
`timescale 1ns/10ps
`include "timetag_consts.svh"

module pulse_seq import timetag_pkg::*; (
	input  logic       fx2_clk,
	input  logic       rst_n,
	input  chan_mask_t pulse_mask,
	output chan_mask_t laser_en
);

	localparam int PW = $clog2(`PULSE_PERIOD);

	logic [PW-1:0] period_cnt;
	logic          phase_on;

	// free running, so every channel shares one phase
	always_ff @(posedge fx2_clk or negedge rst_n) begin
		if (!rst_n)
			period_cnt <= '0;
		else if (period_cnt == PW'(`PULSE_PERIOD - 1))
			period_cnt <= '0;
		else
			period_cnt <= period_cnt + 1'b1;
	end

	assign phase_on = (period_cnt < PW'(`PULSE_WIDTH));

	always_ff @(posedge fx2_clk or negedge rst_n) begin
		if (!rst_n)
			laser_en <= '0;
		else
			laser_en <= phase_on ? pulse_mask : '0;
	end

endmodule

/* rtl/tag_capture.sv */
`timescale 1ns/10ps
`include "timetag_consts.svh"

module tag_capture import timetag_pkg::*; (
	input  logic       fx2_clk,
	input  logic       rst_n,
	input  chan_mask_t detectors,
	input  logic       capture_on,
	input  chan_mask_t det_mask,
	input  logic       clr_ts,
	output tag_rec_t   rec,
	output logic       rec_wr
);

	chan_mask_t sync1;
	chan_mask_t sync2;
	chan_mask_t prev;
	chan_mask_t rise;
	tstamp_t    ts_cnt;

	// ####################################################################
	// synchroniser and edge detect
	// ####################################################################
	always_ff @(posedge fx2_clk or negedge rst_n) begin
		if (!rst_n) begin
			sync1 <= '0;
			sync2 <= '0;
			prev  <= '0;
		end else begin
			sync1 <= detectors;
			sync2 <= sync1;
			prev  <= sync2;
		end
	end

	assign rise = sync2 & ~prev & det_mask;

	// timestamp counter
	always_ff @(posedge fx2_clk or negedge rst_n) begin
		if (!rst_n)
			ts_cnt <= '0;
		else if (clr_ts)
			ts_cnt <= '0;
		else if (capture_on)
			ts_cnt <= ts_cnt + 1'b1;
	end

	always_ff @(posedge fx2_clk or negedge rst_n) begin
		if (!rst_n)
			rec_wr <= 1'b0;
		else
			rec_wr <= capture_on && (rise != '0);
	end

	// all channels that rose in this cycle share one record
	always_ff @(posedge fx2_clk) begin
		rec.chans <= rise;
		rec.ts    <= ts_cnt;
	end

endmodule

/* rtl/tag_fifo.sv */
`timescale 1ns/10ps
`include "timetag_consts.svh"

module tag_fifo import timetag_pkg::*; (
	input  logic     fx2_clk,
	input  logic     rst_n,
	input  tag_rec_t rec,
	input  logic     rec_wr,
	input  logic     sample_ack,
	output byte_t    sample,
	output logic     sample_rdy
);

	localparam int AW = $clog2(`TAG_FIFO_DEPTH);

	tag_rec_t      mem [`TAG_FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic [1:0]    byte_idx;   // 0..2 within the head record
	logic          push;
	logic          pop;
	tag_rec_t      head;

	assign push = rec_wr && (count != (AW+1)'(`TAG_FIFO_DEPTH)); // dropped when full
	assign pop  = sample_ack && (byte_idx == 2'd2);

	always_ff @(posedge fx2_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			byte_idx <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
			if (sample_ack)
				byte_idx <= pop ? 2'd0 : byte_idx + 1'b1;
		end
	end

	always_ff @(posedge fx2_clk) begin
		if (push)
			mem[wr_ptr] <= rec;
	end

	assign head       = mem[rd_ptr];
	assign sample_rdy = (count != '0);

	always_comb begin
		unique case (byte_idx)
			2'd0:    sample = {head.chans, head.ts[19:16]};
			2'd1:    sample = head.ts[15:8];
			default: sample = head.ts[7:0];
		endcase
	end

endmodule

/* rtl/timetag.sv */
`timescale 1ns/10ps
`include "timetag_consts.svh"

module timetag import timetag_pkg::*; (
	input  logic       fx2_clk,
	input  logic       rst_n,
	input  byte_t      cmd,
	input  logic       cmd_wr,
	input  chan_mask_t detectors,
	input  logic       sample_ack,
	output chan_mask_t laser_en,
	output byte_t      sample,
	output logic       sample_rdy,
	output tt_ctrl_t   ctrl,
	output logic       flush
);

	logic     clr_ts;
	tag_rec_t rec;
	logic     rec_wr;

	cmd_decoder decoder (.fx2_clk, .rst_n, .cmd, .cmd_wr, .ctrl, .flush, .clr_ts);

	tag_capture capture (.fx2_clk, .rst_n, .detectors, .capture_on(ctrl.capture_on),
		.det_mask(ctrl.det_mask), .clr_ts, .rec, .rec_wr);

	tag_fifo rec_fifo (.fx2_clk, .rst_n, .rec, .rec_wr, .sample_ack, .sample, .sample_rdy);

	pulse_seq pulses (.fx2_clk, .rst_n, .pulse_mask(ctrl.pulse_mask), .laser_en);

endmodule

/* rtl/timetag_consts.svh */
`ifndef TIMETAG_CONSTS_SVH
`define TIMETAG_CONSTS_SVH

// datapath widths
`define TS_W            20
`define CH_N            4
`define TAG_FIFO_DEPTH  8

`define PULSE_PERIOD    16   // clock cycles
`define PULSE_WIDTH     4

// command opcodes, upper nibble of a command byte
`define OP_START        4'h1
`define OP_STOP         4'h2
`define OP_DET_MASK     4'h3
`define OP_PULSE_ON     4'h4
`define OP_PULSE_OFF    4'h5

`define EP_OUT          2'd0
`define EP_IN           2'd2

`endif

/* rtl/timetag_pkg.sv */
`include "timetag_consts.svh"

package timetag_pkg;

	typedef logic [7:0]        byte_t;       // one FX2 bus byte
	typedef logic [`CH_N-1:0]  chan_mask_t;  // one bit per channel
	typedef logic [`TS_W-1:0]  tstamp_t;

	// 24 bit tag record, sent msb byte first
	typedef struct packed {
		chan_mask_t chans;
		tstamp_t    ts;
	} tag_rec_t;

	typedef struct packed {
		logic       capture_on;
		chan_mask_t det_mask;
		chan_mask_t pulse_mask;
	} tt_ctrl_t;

	typedef enum logic [2:0] {
		idle,
		rd_oe,
		rd_strobe,
		wr_strobe,
		pktend
	} fx2_state_e;

endpackage

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/10ps --top-module tb_fx2_timetag -f tb.f -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

if grep -qx '>>> PASS' sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

/* tb.f */
+incdir+rtl
rtl/timetag_pkg.sv
rtl/fx2_bidir.sv
rtl/cmd_decoder.sv
rtl/tag_capture.sv
rtl/tag_fifo.sv
rtl/pulse_seq.sv
rtl/timetag.sv
rtl/fx2_timetag.sv
verif/tb_fx2_timetag.sv

/* verif/tb_fx2_timetag.sv */
`timescale 1ns/10ps
`include "timetag_consts.svh"

module tb_fx2_timetag import timetag_pkg::*; ();

	localparam int MAX_CYCLES = 4000;   // 22 detector pulses of up to 13 cycles plus pulses and drains

	logic       fx2_clk;
	logic       rst_n;
	logic       in_nf;                  // host IN endpoint has room
	chan_mask_t detectors;
	wire byte_t fx2_fd;
	logic [2:0] fx2_flags;
	logic       fx2_slwr;
	logic       fx2_slrd;
	logic       fx2_sloe;
	logic       fx2_pktend;
	logic [1:0] fx2_fifoadr;
	chan_mask_t laser_en;
	logic [1:0] led;

	byte_t      cmd_mem [0:31];        // OUT endpoint contents
	logic [4:0] cmd_cnt;
	logic [4:0] cmd_rd;
	byte_t      in_q [$];
	chan_mask_t exp_ch_q [$];          // channel field of each predicted record
	int         exp_cyc_q [$];         // and the cycle of their edge
	int         in_bytes;
	int         exp_bytes;
	int         pkt_cnt;
	int         cycle;
	int         value_errs;
	int         proto_errs;
	logic [31:0] lfsr;
	chan_mask_t det_mask_ref;
	tstamp_t    prev_ts;
	int         prev_cyc;
	logic       have_prev;

	assign fx2_flags = {1'b0, in_nf, cmd_rd != cmd_cnt};
	assign fx2_fd    = fx2_sloe ? 'z : cmd_mem[cmd_rd];   // host owns the bus while sloe is low

	fx2_timetag UUT (.fx2_clk, .rst_n, .fx2_flags, .fx2_slwr, .fx2_slrd, .fx2_sloe,
		.fx2_pktend, .fx2_fifoadr, .fx2_fd, .detectors, .laser_en, .led);

	always #10 fx2_clk = ~fx2_clk;

	task automatic check_val(input string name, input int got, input int exp);
		assert (got == exp) else begin
			$display("Fail at %0t: %s = %0h, expected %0h", $time, name, got, exp);
			value_errs++;
		end
	endtask

	task automatic report_problem(input string what);
		$display("Error at %0t: %s", $time, what);
		proto_errs++;
	endtask

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [3:0] rand_bits(input int n);
		logic [3:0] v;
		int         i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v    = {v[2:0], lfsr[0]};
		end
		return v;
	endfunction

	always @(posedge fx2_clk) begin
		cycle <= cycle + 1;
		if (cycle == MAX_CYCLES) begin
			$display("timeout after %0d cycles, the test phases did not complete", MAX_CYCLES);
			$display(">>> FAIL");
			$finish;
		end
	end

	// ####################################################################
	// FX2 host model
	// ####################################################################
	always @(posedge fx2_clk) begin
		if (rst_n && !fx2_slrd) begin
			cmd_rd <= cmd_rd + 1'b1;   // pop the byte just read
			check_val("fx2_fifoadr", int'(fx2_fifoadr), int'(`EP_OUT));
		end
		if (rst_n && !fx2_slwr) begin
			in_q.push_back(fx2_fd);
			in_bytes <= in_bytes + 1;
			check_val("fx2_fifoadr", int'(fx2_fifoadr), int'(`EP_IN));
		end
		if (rst_n && !fx2_pktend) begin
			pkt_cnt <= pkt_cnt + 1;
			check_val("fx2_fifoadr", int'(fx2_fifoadr), int'(`EP_IN));
			check_val("IN bytes at pktend", in_bytes, exp_bytes);
		end
	end

	assert property (@(posedge fx2_clk) disable iff (!rst_n) fx2_slwr || fx2_slrd)
		else report_problem("slwr and slrd were low in the same cycle");
	assert property (@(posedge fx2_clk) disable iff (!rst_n) !fx2_slrd |-> fx2_flags[0])
		else report_problem("slrd strobed while the OUT endpoint was empty");
	assert property (@(posedge fx2_clk) disable iff (!rst_n) !fx2_slwr |-> $past(fx2_flags[1]))
		else report_problem("slwr strobed while the IN endpoint was full");

	task automatic send_cmd(input logic [3:0] op, input logic [3:0] arg);
		@(posedge fx2_clk);
		cmd_mem[cmd_cnt] <= {op, arg};
		cmd_cnt          <= cmd_cnt + 1'b1;
	endtask

	// one detector pulse two cycles high followed by a random gap
	task automatic fire_edge(input chan_mask_t chans, input logic capture);
		chan_mask_t seen;
		int         gap;
		seen = chans & det_mask_ref;
		@(posedge fx2_clk);
		detectors <= chans;
		if (capture && seen != '0) begin
			exp_ch_q.push_back(seen);
			exp_cyc_q.push_back(cycle);
			exp_bytes += 3;
		end
		repeat (2) @(posedge fx2_clk);
		detectors <= '0;
		gap = 3 + int'(rand_bits(3));
		repeat (gap) @(posedge fx2_clk);
	endtask

	task automatic wait_drained();
		while (in_bytes < exp_bytes)
			@(posedge fx2_clk);
	endtask

	task automatic check_records();
		chan_mask_t ch;
		int         cyc;
		byte_t      b0;
		byte_t      b1;
		byte_t      b2;
		tstamp_t    ts;
		tstamp_t    dts;
		while (exp_ch_q.size() > 0 && in_q.size() >= 3) begin
			ch  = exp_ch_q.pop_front();
			cyc = exp_cyc_q.pop_front();
			b0  = in_q.pop_front();
			b1  = in_q.pop_front();
			b2  = in_q.pop_front();
			ts  = {b0[3:0], b1, b2};
			dts = ts - prev_ts;
			check_val("tag chans", int'(b0[7:4]), int'(ch));
			if (have_prev)
				check_val("tag ts delta", int'(dts), cyc - prev_cyc);   // edge spacing
			prev_ts   = ts;
			prev_cyc  = cyc;
			have_prev = 1'b1;
		end
		if (exp_ch_q.size() != 0 || in_q.size() != 0)
			report_problem("IN stream and predicted records differ in length");
	endtask

	task automatic check_pulses(input chan_mask_t mask);
		int   high_cnt;
		int   rise_cnt;
		logic was_on;
		high_cnt = 0;
		rise_cnt = 0;
		@(posedge fx2_clk);
		was_on = (laser_en != '0);
		repeat (2 * `PULSE_PERIOD) begin
			@(posedge fx2_clk);
			if (laser_en != '0) begin
				high_cnt++;
				check_val("laser_en", int'(laser_en), int'(mask));
				if (!was_on)
					rise_cnt++;
			end
			was_on = (laser_en != '0);
		end
		// the window spans exactly two pulse periods
		check_val("laser_en high cycles", high_cnt, (mask == '0) ? 0 : 2 * `PULSE_WIDTH);
		check_val("laser_en pulse starts", rise_cnt, (mask == '0) ? 0 : 2);
		check_val("led[1]", int'(led[1]), int'(mask != '0));
	endtask

	initial begin
		int i;
		int bp_bytes;
		fx2_clk      = 1'b0;
		rst_n        = 1'b0;
		in_nf        = 1'b1;
		detectors    = '0;
		cmd_cnt      = '0;
		cmd_rd       = '0;
		in_bytes     = 0;
		exp_bytes    = 0;
		pkt_cnt      = 0;
		cycle        = 0;
		value_errs   = 0;
		proto_errs   = 0;
		lfsr         = 32'hb903_6eac;
		det_mask_ref = '0;
		have_prev    = 1'b0;
		prev_ts      = '0;
		prev_cyc     = 0;
		repeat (3) @(posedge fx2_clk);
		rst_n <= 1'b1;
		@(posedge fx2_clk);
		check_val("fx2_slrd", int'(fx2_slrd), 1);
		check_val("fx2_slwr", int'(fx2_slwr), 1);
		check_val("fx2_sloe", int'(fx2_sloe), 1);
		check_val("fx2_pktend", int'(fx2_pktend), 1);
		check_val("laser_en", int'(laser_en), 0);
		check_val("led", int'(led), 0);

		// ####################################################################
		// capture with channel 2 masked off
		// ####################################################################
		send_cmd(`OP_DET_MASK, 4'b1011);
		det_mask_ref = 4'b1011;
		send_cmd(`OP_START, 4'h0);
		while (!led[0])
			@(posedge fx2_clk);
		for (i = 0; i < 12; i++)
			fire_edge(rand_bits(4), 1'b1);
		fire_edge(4'b0100, 1'b1);   // masked channel alone
		wait_drained();
		check_records();

		// records wait in the FIFO while the IN endpoint is full
		@(posedge fx2_clk);
		in_nf    <= 1'b0;
		bp_bytes  = in_bytes;
		for (i = 0; i < 6; i++)
			fire_edge(rand_bits(4) | 4'b0001, 1'b1);
		check_val("IN bytes while full", in_bytes, bp_bytes);
		in_nf <= 1'b1;
		wait_drained();
		check_records();

		// ####################################################################
		// laser pulses
		// ####################################################################
		send_cmd(`OP_PULSE_ON, 4'b0101);
		while (!led[1])
			@(posedge fx2_clk);
		check_pulses(4'b0101);
		send_cmd(`OP_PULSE_OFF, 4'b0101);
		while (led[1])
			@(posedge fx2_clk);
		check_pulses('0);

		// stop ends the packet and later edges give nothing
		send_cmd(`OP_STOP, 4'h0);
		while (pkt_cnt == 0)
			@(posedge fx2_clk);
		repeat (30) @(posedge fx2_clk);
		check_val("pktend strobes", pkt_cnt, 1);
		check_val("led[0]", int'(led[0]), 0);
		for (i = 0; i < 3; i++)
			fire_edge(4'b1011, 1'b0);
		repeat (10) @(posedge fx2_clk);
		check_val("IN bytes with capture off", in_bytes, exp_bytes);

		$display("errors: %0d value, %0d protocol", value_errs, proto_errs);
		if (value_errs == 0 && proto_errs == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule
